// File: files.f
logic/link_cfg_pkg.sv
logic/link_proto_pkg.sv
logic/link_piso.sv
logic/link_channel_upstream.sv
logic/link_ddr_phy.sv
logic/link_ddr_upstream.sv
logic/link_channel_downstream.sv
logic/link_sipo.sv
logic/link_loopback_top.sv
testbench/tb_clock_gen.sv
testbench/link_loopback_tb.sv

// File: logic/link_cfg_pkg.sv
package link_cfg_pkg;

  // Default link shape for the loopback top and its testbench.
  localparam int default_width_c         = 32;
  localparam int default_channel_width_c = 4;
  localparam int default_num_channel_c   = 2;
  localparam int default_lg_fifo_depth_c = 3;
  localparam int default_lg_decimation_c = 1;

  // Number of channel groups that one wide word is cut into.
  function automatic int piso_els_f(input int width, input int group_width);
    if (group_width >= width) begin
      return 1;
    end
    return width / group_width;
  endfunction

  // Width of an index over els entries, at least one bit.
  function automatic int index_width_f(input int els);
    return (els > 1) ? $clog2(els) : 1;
  endfunction

endpackage

// File: logic/link_channel_downstream.sv
module link_channel_downstream
 #(parameter int channel_width_p = 4
  ,parameter int lg_fifo_depth_p = 3
  ,parameter int lg_decimation_p = 1
  ,localparam int word_width_lp  = channel_width_p * 2)
  (input  logic                       clk_i
  ,input  logic                       reset_i
  ,input  link_proto_pkg::link_beat_s beat_i
  ,output logic [word_width_lp-1:0]   data_o
  ,output logic                       valid_o
  ,input  logic                       yumi_i
  ,output logic                       token_o);

  import link_proto_pkg::*;

  localparam int depth_lp       = 1 << lg_fifo_depth_p;
  localparam int count_width_lp = lg_fifo_depth_p + 1;
  localparam int dec_width_lp   = lg_decimation_p + 1;
  localparam logic [count_width_lp-1:0] full_count_lp = count_width_lp'(depth_lp);
  localparam logic [dec_width_lp-1:0] release_last_lp =
    dec_width_lp'((1 << lg_decimation_p) - 1);

  rx_state_e                               rx_state_r;
  logic [channel_width_p-1:0]              low_r;
  logic [word_width_lp-1:0]                word_r;
  logic                                    word_v_r;
  logic [depth_lp-1:0][word_width_lp-1:0]  mem_r;
  logic [lg_fifo_depth_p-1:0]              wptr_r;
  logic [lg_fifo_depth_p-1:0]              rptr_r;
  logic [count_width_lp-1:0]               count_r;
  logic                                    full;
  logic [dec_width_lp-1:0]                 release_cnt_r;
  logic                                    token_r;

  assign full    = (count_r == full_count_lp);
  assign valid_o = (count_r != '0);
  assign data_o  = mem_r[rptr_r];
  assign token_o = token_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_state_r    <= rx_want_low_e;
      word_v_r      <= 1'b0;
      wptr_r        <= '0;
      rptr_r        <= '0;
      count_r       <= '0;
      release_cnt_r <= '0;
      token_r       <= 1'b0;
    end else begin
      word_v_r <= beat_i.valid & (rx_state_r == rx_want_high_e);
      if (beat_i.valid) begin
        rx_state_r <= (rx_state_r == rx_want_low_e) ? rx_want_high_e : rx_want_low_e;
      end
      if (word_v_r) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (yumi_i) begin
        rptr_r <= rptr_r + 1'b1;
      end
      count_r <= count_r + count_width_lp'(word_v_r) - count_width_lp'(yumi_i);
      // One token goes back per block of released words.
      token_r <= 1'b0;
      if (yumi_i) begin
        if (release_cnt_r == release_last_lp) begin
          release_cnt_r <= '0;
          token_r       <= 1'b1;
        end else begin
          release_cnt_r <= release_cnt_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_i.valid && rx_state_r == rx_want_low_e) begin
      low_r <= beat_i.data[channel_width_p-1:0];
    end
    if (beat_i.valid && rx_state_r == rx_want_high_e) begin
      word_r <= {beat_i.data[channel_width_p-1:0], low_r};
    end
    if (word_v_r) begin
      mem_r[wptr_r] <= word_r;
    end
  end

  // Upstream credits keep beats away while every slot here is taken.
  no_beat_when_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_i.valid |-> !full);

  // Back to back beats from the PHY always flip the strobe.
  strobe_toggles_a: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_i.valid && $past(beat_i.valid) |-> beat_i.strobe != $past(beat_i.strobe));

endmodule

// File: logic/link_channel_upstream.sv
module link_channel_upstream
 #(parameter int width_p         = 8
  ,parameter int lg_fifo_depth_p = 3
  ,parameter int lg_decimation_p = 1
  ,localparam int credit_width_lp = lg_fifo_depth_p + 1)
  (input  logic               clk_i
  ,input  logic               reset_i
  ,input  logic               link_enable_i
  ,input  logic [width_p-1:0] data_i
  ,input  logic               valid_i
  ,output logic               ready_o
  ,input  logic               token_i
  ,output logic [width_p-1:0] phy_data_o
  ,output logic               phy_valid_o
  ,input  logic               phy_ready_i);

  localparam logic [credit_width_lp-1:0] credit_max_lp =
    credit_width_lp'(1 << lg_fifo_depth_p);
  // Each token stands for this many words drained on the far side.
  localparam logic [credit_width_lp-1:0] token_step_lp =
    credit_width_lp'(1 << lg_decimation_p);

  logic [credit_width_lp-1:0] credit_r;
  logic [width_p-1:0]         data_r;
  logic                       valid_r;
  logic                       send;
  logic                       phy_take;

  assign phy_take = valid_r & phy_ready_i;

  // A slice is taken only with a free slot downstream and room in the hold register.
  assign ready_o = link_enable_i & (credit_r != '0) & (~valid_r | phy_ready_i);
  assign send    = valid_i & ready_o;

  assign phy_data_o  = data_r;
  assign phy_valid_o = valid_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= credit_max_lp;
      valid_r  <= 1'b0;
    end else begin
      credit_r <= credit_r - credit_width_lp'(send) + (token_i ? token_step_lp : '0);
      if (send) begin
        valid_r <= 1'b1;
      end else if (phy_take) begin
        valid_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      data_r <= data_i;
    end
  end

  // Tokens never return more slots than the receive FIFO holds.
  credit_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_r <= credit_max_lp);

endmodule

// File: logic/link_ddr_phy.sv
module link_ddr_phy
 #(parameter int channel_width_p = 4)
  (input  logic                         clk_i
  ,input  logic                         reset_i
  ,input  logic [2*channel_width_p-1:0] data_i
  ,input  logic                         valid_i
  ,output logic                         ready_o
  ,output link_proto_pkg::link_beat_s   beat_o);

  import link_proto_pkg::*;

  phy_state_e                   state_r;
  phy_state_e                   state_n;
  logic [2*channel_width_p-1:0] data_r;
  logic                         strobe_r;
  logic                         take;

  // The next word may enter while the high half of the current one is on the wire.
  assign ready_o = (state_r != phy_low_beat_e);
  assign take    = valid_i & ready_o;

  always_comb begin
    case (state_r)
      phy_low_beat_e:  state_n = phy_high_beat_e;
      phy_high_beat_e: state_n = take ? phy_low_beat_e : phy_idle_e;
      default:         state_n = take ? phy_low_beat_e : phy_idle_e;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= phy_idle_e;
      strobe_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r != phy_idle_e) begin
        strobe_r <= ~strobe_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_r <= data_i;
    end
  end

  always_comb begin
    beat_o        = '0;
    beat_o.valid  = (state_r != phy_idle_e);
    beat_o.strobe = strobe_r;
    if (state_r == phy_low_beat_e) begin
      beat_o.data[channel_width_p-1:0] = data_r[channel_width_p-1:0];
    end else if (state_r == phy_high_beat_e) begin
      beat_o.data[channel_width_p-1:0] = data_r[2*channel_width_p-1:channel_width_p];
    end
  end

endmodule

// File: logic/link_ddr_upstream.sv
module link_ddr_upstream
 #(parameter int width_p         = 32
  ,parameter int channel_width_p = 4
  ,parameter int num_channel_p   = 2
  ,parameter int lg_fifo_depth_p = 3
  ,parameter int lg_decimation_p = 1
  ,localparam int ddr_width_lp   = channel_width_p * 2
  ,localparam int group_width_lp = ddr_width_lp * num_channel_p
  ,localparam int els_lp         = link_cfg_pkg::piso_els_f(width_p, group_width_lp))
  (input  logic                                         clk_i
  ,input  logic                                         reset_i
  ,input  logic                                         link_enable_i
  ,input  logic [width_p-1:0]                           data_i
  ,input  logic                                         valid_i
  ,output logic                                         ready_o
  ,output link_proto_pkg::link_beat_s [num_channel_p-1:0] beat_o
  ,input  logic [num_channel_p-1:0]                     token_i);

  logic [num_channel_p-1:0][ddr_width_lp-1:0] group_data;
  logic                                       group_valid;
  logic                                       group_yumi;
  logic [num_channel_p-1:0]                   ch_ready;

  // All channels take their slice together, so a group moves only when each has room.
  assign group_yumi = group_valid & (&ch_ready);

  link_piso
   #(.width_p(width_p)
    ,.slice_width_p(group_width_lp)
    ,.els_p(els_lp))
    piso_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(data_i)
    ,.valid_i(valid_i)
    ,.ready_o(ready_o)
    ,.data_o(group_data)
    ,.valid_o(group_valid)
    ,.yumi_i(group_yumi));

  for (genvar i = 0; i < num_channel_p; i++) begin : ch
    logic [ddr_width_lp-1:0] phy_data;
    logic                    phy_valid;
    logic                    phy_ready;

    link_channel_upstream
     #(.width_p(ddr_width_lp)
      ,.lg_fifo_depth_p(lg_fifo_depth_p)
      ,.lg_decimation_p(lg_decimation_p))
      channel_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.link_enable_i(link_enable_i)
      ,.data_i(group_data[i])
      ,.valid_i(group_yumi)
      ,.ready_o(ch_ready[i])
      ,.token_i(token_i[i])
      ,.phy_data_o(phy_data)
      ,.phy_valid_o(phy_valid)
      ,.phy_ready_i(phy_ready));

    link_ddr_phy
     #(.channel_width_p(channel_width_p))
      phy_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.data_i(phy_data)
      ,.valid_i(phy_valid)
      ,.ready_o(phy_ready)
      ,.beat_o(beat_o[i]));
  end

endmodule

// File: logic/link_loopback_top.sv
// width_p must be a whole multiple of 2 * channel_width_p * num_channel_p.
module link_loopback_top
 #(parameter int width_p         = link_cfg_pkg::default_width_c
  ,parameter int channel_width_p = link_cfg_pkg::default_channel_width_c
  ,parameter int num_channel_p   = link_cfg_pkg::default_num_channel_c
  ,parameter int lg_fifo_depth_p = link_cfg_pkg::default_lg_fifo_depth_c
  ,parameter int lg_decimation_p = link_cfg_pkg::default_lg_decimation_c
  ,localparam int ddr_width_lp   = channel_width_p * 2)
  (input  logic               clk_i
  ,input  logic               reset_i
  ,input  logic               link_enable_i
  ,input  logic [width_p-1:0] data_i
  ,input  logic               valid_i
  ,output logic               ready_o
  ,output logic [width_p-1:0] data_o
  ,output logic               valid_o
  ,input  logic               ready_i);

  import link_proto_pkg::*;

  link_beat_s [num_channel_p-1:0]             beat;
  logic [num_channel_p-1:0]                   token;
  logic [num_channel_p-1:0][ddr_width_lp-1:0] rx_data;
  logic [num_channel_p-1:0]                   rx_valid;
  logic                                       rx_yumi;

  link_ddr_upstream
   #(.width_p(width_p)
    ,.channel_width_p(channel_width_p)
    ,.num_channel_p(num_channel_p)
    ,.lg_fifo_depth_p(lg_fifo_depth_p)
    ,.lg_decimation_p(lg_decimation_p))
    upstream_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.link_enable_i(link_enable_i)
    ,.data_i(data_i)
    ,.valid_i(valid_i)
    ,.ready_o(ready_o)
    ,.beat_o(beat)
    ,.token_i(token));

  for (genvar i = 0; i < num_channel_p; i++) begin : ds
    link_channel_downstream
     #(.channel_width_p(channel_width_p)
      ,.lg_fifo_depth_p(lg_fifo_depth_p)
      ,.lg_decimation_p(lg_decimation_p))
      downstream_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.beat_i(beat[i])
      ,.data_o(rx_data[i])
      ,.valid_o(rx_valid[i])
      ,.yumi_i(rx_yumi)
      ,.token_o(token[i]));
  end

  link_sipo
   #(.width_p(width_p)
    ,.channel_width_p(ddr_width_lp)
    ,.num_channel_p(num_channel_p))
    sipo_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(rx_data)
    ,.valid_i(rx_valid)
    ,.yumi_o(rx_yumi)
    ,.data_o(data_o)
    ,.valid_o(valid_o)
    ,.ready_i(ready_i));

endmodule

// File: logic/link_piso.sv
module link_piso
 #(parameter int width_p       = 32
  ,parameter int slice_width_p = 16
  ,parameter int els_p         = 2)
  (input  logic                     clk_i
  ,input  logic                     reset_i
  ,input  logic [width_p-1:0]       data_i
  ,input  logic                     valid_i
  ,output logic                     ready_o
  ,output logic [slice_width_p-1:0] data_o
  ,output logic                     valid_o
  ,input  logic                     yumi_i);

  import link_proto_pkg::*;

  if (els_p == 1) begin : fifo
    // The word already fits the channels, so two entries keep the input streaming.
    logic [1:0][width_p-1:0] mem_r;
    logic                    wptr_r;
    logic                    rptr_r;
    logic [1:0]              count_r;
    logic                    enq;

    assign enq     = valid_i & ready_o;
    assign ready_o = (count_r != 2'd2);
    assign valid_o = (count_r != 2'd0);
    assign data_o  = mem_r[rptr_r];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wptr_r  <= 1'b0;
        rptr_r  <= 1'b0;
        count_r <= 2'd0;
      end else begin
        if (enq) begin
          wptr_r <= ~wptr_r;
        end
        if (yumi_i) begin
          rptr_r <= ~rptr_r;
        end
        count_r <= count_r + 2'(enq) - 2'(yumi_i);
      end
    end

    always_ff @(posedge clk_i) begin
      if (enq) begin
        mem_r[wptr_r] <= data_i;
      end
    end
  end else begin : shift
    localparam int idx_width_lp = $clog2(els_p);

    piso_state_e                         state_r;
    logic [els_p-1:0][slice_width_p-1:0] word_r;
    logic [idx_width_lp-1:0]             idx_r;
    logic                                last;

    assign last    = (idx_r == idx_width_lp'(els_p - 1));
    assign ready_o = (state_r == piso_empty_e);
    assign valid_o = (state_r == piso_shifting_e);
    assign data_o  = word_r[idx_r];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        state_r <= piso_empty_e;
        idx_r   <= '0;
      end else if (valid_i & ready_o) begin
        state_r <= piso_shifting_e;
        idx_r   <= '0;
      end else if (yumi_i) begin
        if (last) begin
          state_r <= piso_empty_e;
          idx_r   <= '0;
        end else begin
          idx_r <= idx_r + 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (valid_i & ready_o) begin
        word_r <= data_i;
      end
    end
  end

  // The channels may only take a group that is on offer.
  yumi_needs_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> valid_o);

endmodule

// File: logic/link_proto_pkg.sv
package link_proto_pkg;

  // Widest beat a channel can carry. channel_width_p must not exceed it.
  localparam int beat_max_width_c = 8;

  // Wire state of one channel for one cycle.
  typedef struct packed {
    logic                        valid;
    logic                        strobe;
    logic [beat_max_width_c-1:0] data;
  } link_beat_s;

  typedef enum logic [1:0] {
    phy_idle_e,
    phy_low_beat_e,
    phy_high_beat_e
  } phy_state_e;

  typedef enum logic {
    piso_empty_e,
    piso_shifting_e
  } piso_state_e;

  typedef enum logic {
    rx_want_low_e,
    rx_want_high_e
  } rx_state_e;

endpackage

// File: logic/link_sipo.sv
module link_sipo
 #(parameter int width_p         = 32
  ,parameter int channel_width_p = 8
  ,parameter int num_channel_p   = 2
  ,localparam int group_width_lp = channel_width_p * num_channel_p
  ,localparam int els_lp         = link_cfg_pkg::piso_els_f(width_p, group_width_lp)
  ,localparam int idx_width_lp   = link_cfg_pkg::index_width_f(els_lp))
  (input  logic                                          clk_i
  ,input  logic                                          reset_i
  ,input  logic [num_channel_p-1:0][channel_width_p-1:0] data_i
  ,input  logic [num_channel_p-1:0]                      valid_i
  ,output logic                                          yumi_o
  ,output logic [width_p-1:0]                            data_o
  ,output logic                                          valid_o
  ,input  logic                                          ready_i);

  logic [els_lp-1:0][group_width_lp-1:0] word_r;
  logic [idx_width_lp-1:0]               idx_r;
  logic                                  full_r;
  logic                                  last;

  assign last = (idx_r == idx_width_lp'(els_lp - 1));

  // A new group may land in slot zero while the finished word is being taken.
  assign yumi_o  = (&valid_i) & (~full_r | ready_i);
  assign valid_o = full_r;
  assign data_o  = word_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_r  <= '0;
      full_r <= 1'b0;
    end else begin
      if (yumi_o) begin
        idx_r <= last ? '0 : idx_r + 1'b1;
      end
      if (yumi_o & last) begin
        full_r <= 1'b1;
      end else if (ready_i) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      word_r[idx_r] <= data_i;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the loopback testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module link_loopback_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

./obj_dir/Vlink_loopback_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
  echo "run_sim: failure reported in $log_file"
  exit 1
fi

echo "run_sim: no failure reported in $log_file"
exit 0

// File: testbench/link_loopback_tb.sv
module link_loopback_tb;

  import link_cfg_pkg::*;

  localparam int width_c       = default_width_c;
  localparam int num_tests_c   = 4;
  localparam int block_limit_c = (1 << default_lg_fifo_depth_c) + 4;
  // Cycles that ready_o has to stay low before the blocked sink is released.
  localparam int block_hold_c  = 40;
  localparam int enable_hold_c = 60;

  typedef enum logic [1:0] {stall_none_e, stall_block_e, stall_random_e} stall_e;
  typedef enum logic {enable_on_e, enable_late_e} enable_e;

  typedef struct packed {
    logic [15:0] words;
    stall_e      stall;
    enable_e     enable;
    logic [15:0] max_accept;
  } test_row_s;

  string test_name [num_tests_c] =
    '{"full_rate", "sink_blocked", "enable_gated", "random_stalls"};

  test_row_s test_row [num_tests_c] = '{
    '{16'd40, stall_none_e,   enable_on_e,   16'd0},
    '{16'd20, stall_block_e,  enable_on_e,   16'(block_limit_c)},
    '{16'd16, stall_none_e,   enable_late_e, 16'd0},
    '{16'd60, stall_random_e, enable_on_e,   16'd0}
  };

  logic               clk_i;
  logic               reset_i;
  logic               link_enable_i;
  logic [width_c-1:0] data_i;
  logic               valid_i;
  logic               ready_o;
  logic [width_c-1:0] data_o;
  logic               valid_o;
  logic               ready_i;

  logic [width_c-1:0] expected_q [$];
  int                 error_count;
  int                 tests_passed;
  int                 tests_failed;

  tb_clock_gen #(.period_p(4)) clock_gen_inst (.clk_o(clk_i));

  link_loopback_top
   #(.width_p(default_width_c)
    ,.channel_width_p(default_channel_width_c)
    ,.num_channel_p(default_num_channel_c)
    ,.lg_fifo_depth_p(default_lg_fifo_depth_c)
    ,.lg_decimation_p(default_lg_decimation_c))
    link_loopback_top_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.link_enable_i(link_enable_i)
    ,.data_i(data_i)
    ,.valid_i(valid_i)
    ,.ready_o(ready_o)
    ,.data_o(data_o)
    ,.valid_o(valid_o)
    ,.ready_i(ready_i));

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = error_count;
    if (ready_o !== 1'b1) begin
      $display("error in reset_state: ready_o is not high after reset");
      error_count++;
    end
    if (valid_o !== 1'b0) begin
      $display("error in reset_state: valid_o is not low after reset");
      error_count++;
    end
    finish_test("reset_state", errors_before);
  endtask

  // Inputs change on the falling edge. The DUT outputs only move on the rising edge,
  // so both handshakes for the coming rising edge are already settled here.
  task automatic run_test(input int t);
    int                 sent;
    int                 received;
    int                 errors_before;
    int                 low_run;
    int                 cycle;
    logic               blocking;
    logic               accepted_prev;
    logic               offer;
    logic [width_c-1:0] expected;
    sent          = 0;
    received      = 0;
    errors_before = error_count;
    low_run       = 0;
    cycle         = 0;
    accepted_prev = 1'b0;
    blocking      = (test_row[t].stall == stall_block_e);
    while (received < int'(test_row[t].words)) begin
      @(negedge clk_i);
      link_enable_i = (test_row[t].enable == enable_on_e) || (cycle >= enable_hold_c);
      if (accepted_prev) begin
        valid_i = 1'b0;
      end
      accepted_prev = 1'b0;
      offer = (test_row[t].stall != stall_random_e) || ($urandom_range(3, 0) != 0);
      if (!valid_i && offer && sent < int'(test_row[t].words)) begin
        data_i  = $urandom;
        valid_i = 1'b1;
      end
      if (valid_i && ready_o) begin
        expected_q.push_back(data_i);
        sent++;
        accepted_prev = 1'b1;
      end
      if (blocking) begin
        low_run = ready_o ? 0 : low_run + 1;
        if (sent > int'(test_row[t].max_accept) || sent == int'(test_row[t].words)) begin
          $display("error in %s: ready_o still high after %0d accepted words",
                   test_name[t], sent);
          error_count++;
          blocking = 1'b0;
        end else if (low_run >= block_hold_c) begin
          blocking = 1'b0;
        end
      end
      case (test_row[t].stall)
        stall_block_e:  ready_i = !blocking;
        stall_random_e: ready_i = ($urandom_range(2, 0) != 0);
        default:        ready_i = 1'b1;
      endcase
      if (!link_enable_i && valid_o) begin
        $display("error in %s: a word reached the output while the link was disabled",
                 test_name[t]);
        error_count++;
      end
      if (valid_o && ready_i) begin
        if (expected_q.size() == 0) begin
          $display("error in %s: word %08h came out with none outstanding",
                   test_name[t], data_o);
          error_count++;
        end else begin
          expected = expected_q.pop_front();
          if (data_o !== expected) begin
            $display("mismatch in %s: expected %08h, actual %08h",
                     test_name[t], expected, data_o);
            error_count++;
          end
        end
        received++;
      end
      cycle++;
    end
    valid_i = 1'b0;
    if (expected_q.size() != 0) begin
      $display("error in %s: %0d accepted words were never delivered",
               test_name[t], expected_q.size());
      error_count++;
      expected_q.delete();
    end
    finish_test(test_name[t], errors_before);
  endtask

  initial begin : watchdog
    int total_words;
    total_words = 0;
    for (int t = 0; t < num_tests_c; t++) begin
      total_words += int'(test_row[t].words);
    end
    repeat (40 * total_words + 200) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", 40 * total_words + 200);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(90));
    error_count   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    reset_i       = 1'b1;
    link_enable_i = 1'b1;
    data_i        = '0;
    valid_i       = 1'b0;
    ready_i       = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_reset_state();
    for (int t = 0; t < num_tests_c; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen
 #(parameter int period_p = 4)
  (output logic clk_o);

  // Free-running clock that starts low, so the first rising edge comes after half a period.
  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_p / 2) clk_o = ~clk_o;
    end
  end

endmodule
